/* source/memsched_pkg.sv */
/*
 * Shared widths, integer formats and tile constants of the memory scheduler.
 * Imported by every scheduler module and by the checker.
 */

`default_nettype none

package memsched_pkg;

  // Byte address or address offset
  typedef logic [31:0] addr_t;

  // Iteration count or count limit
  typedef logic [15:0] iter_t;

  // Quantized-integer format of the packed weights
  typedef enum logic [1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  // Bytes moved per memory beat
  localparam int unsigned BusBytes = 32'd4;

  // Beats in one tile column
  localparam int unsigned BeatsPerTile = 32'd8;

  // Byte step between two neighbouring tile columns
  localparam int unsigned TileJump = BusBytes * (BeatsPerTile - 1);

  // Narrowing shift of a stride for each format.
  // QINT_8 keeps the stride, QINT_4 halves it, QINT_2 quarters it.
  // Unused encodings fall back to the 8-bit behaviour
  function automatic logic [1:0] qint_shift(qint_fmt_e fmt);
    logic [1:0] shift;
    case (fmt)
      QINT_4:  shift = 2'd1;
      QINT_2:  shift = 2'd2;
      default: shift = 2'd0;
    endcase
    return shift;
  endfunction

endpackage : memsched_pkg

`default_nettype wire

/* source/x_tile_walker.sv */
/*
 * Walks the X operand tile by tile on each X-stream done pulse and gives the
 * X address offset, the rows to read in the current tile and the read total.
 */

`timescale 1ns/1ps
`default_nettype none

module x_tile_walker
  import memsched_pkg::*;
#(
  parameter int unsigned ArrayWidth = 8,
  localparam int unsigned ReadsW = $clog2(ArrayWidth) + 1
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              clear_i,
  input  wire logic              x_done_i,
  input  wire iter_t             cfg_x_col_iters_i,
  input  wire iter_t             cfg_w_iters_i,
  input  wire iter_t             cfg_x_row_iters_i,
  input  wire addr_t             cfg_x_rows_offs_i,
  input  wire iter_t             cfg_x_leftover_i,
  output addr_t                  x_offs_o,
  output logic [ReadsW-1:0]      x_reads_o,
  output iter_t                  x_read_cnt_o
);

  iter_t col_cnt_q;
  iter_t w_cnt_q;
  iter_t row_cnt_q;
  iter_t read_cnt_q;

  iter_t col_max;
  iter_t w_max;
  iter_t row_max;

  addr_t col_offs_q;
  addr_t row_offs_q;

  logic  col_last;
  logic  w_last;
  logic  row_last;
  logic  row_step;

  assign col_max = cfg_x_col_iters_i - iter_t'(1);
  assign w_max   = cfg_w_iters_i - iter_t'(1);
  assign row_max = cfg_x_row_iters_i - iter_t'(1);

  assign col_last = (col_cnt_q == col_max);
  assign w_last   = (w_cnt_q == w_max);
  assign row_last = (row_cnt_q == row_max);

  // A new row tile starts once every column has met every weight tile
  assign row_step = x_done_i && col_last && w_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin : iter_counters
    if (!rst_ni) begin
      col_cnt_q <= '0;
      w_cnt_q   <= '0;
      row_cnt_q <= '0;
    end else if (clear_i) begin
      col_cnt_q <= '0;
      w_cnt_q   <= '0;
      row_cnt_q <= '0;
    end else begin
      if (x_done_i) begin
        col_cnt_q <= col_last ? '0 : col_cnt_q + iter_t'(1);
      end
      if (x_done_i && col_last) begin
        w_cnt_q <= w_last ? '0 : w_cnt_q + iter_t'(1);
      end
      if (row_step) begin
        row_cnt_q <= row_last ? '0 : row_cnt_q + iter_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : tile_offsets
    if (!rst_ni) begin
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear_i) begin
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else begin
      if (x_done_i) begin
        col_offs_q <= col_last ? '0 : col_offs_q + addr_t'(TileJump);
      end
      if (row_step) begin
        row_offs_q <= row_last ? '0 : row_offs_q + cfg_x_rows_offs_i;
      end
    end
  end

  // Total of X tiles fetched in this job
  always_ff @(posedge clk_i or negedge rst_ni) begin : read_counter
    if (!rst_ni) begin
      read_cnt_q <= '0;
    end else if (clear_i) begin
      read_cnt_q <= '0;
    end else if (x_done_i) begin
      read_cnt_q <= read_cnt_q + iter_t'(1);
    end
  end

  assign x_offs_o = col_offs_q + row_offs_q;

  // Last row tile may be only partly filled
  assign x_reads_o = (row_last && cfg_x_leftover_i != '0) ? cfg_x_leftover_i[ReadsW-1:0]
                                                          : ReadsW'(ArrayWidth);

  assign x_read_cnt_o = read_cnt_q;

  // Column counter stays inside the configured column count
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_x_col_iters_i != '0 |-> col_cnt_q <= col_max);

endmodule : x_tile_walker

`default_nettype wire

/* source/stream_config.sv */
/*
 * Two-dimension address-generator settings and start requests for the X, W
 * and Z streams. Purely combinational apart from the read-count check.
 */

`timescale 1ns/1ps
`default_nettype none

module stream_config
  import memsched_pkg::*;
#(
  parameter int unsigned ArrayWidth = 8,
  localparam int unsigned ReadsW = $clog2(ArrayWidth) + 1
) (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire addr_t        cfg_x_addr_i,
  input  wire addr_t        cfg_w_addr_i,
  input  wire addr_t        cfg_scales_addr_i,
  input  wire addr_t        cfg_z_addr_i,
  input  wire addr_t        cfg_x_d1_stride_i,
  input  wire addr_t        cfg_w_d0_stride_i,
  input  wire addr_t        cfg_z_d0_stride_i,
  input  wire addr_t        cfg_w_tot_len_i,
  input  wire addr_t        cfg_z_tot_len_i,
  input  wire iter_t        cfg_w_iters_i,
  input  wire iter_t        cfg_w_rows_i,
  input  wire iter_t        cfg_tot_x_read_i,
  input  wire logic         cfg_dequant_en_i,
  input  wire addr_t        x_offs_i,
  input  wire [ReadsW-1:0]  x_reads_i,
  input  wire iter_t        x_read_cnt_i,
  input  wire logic         first_load_i,
  input  wire logic         x_ready_start_i,
  input  wire logic         w_ready_start_i,
  input  wire logic         z_ready_start_i,
  output addr_t             x_base_addr_o,
  output addr_t             x_tot_len_o,
  output iter_t             x_d0_len_o,
  output addr_t             x_d0_stride_o,
  output iter_t             x_d1_len_o,
  output addr_t             x_d1_stride_o,
  output logic              x_req_start_o,
  output addr_t             w_base_addr_o,
  output addr_t             w_tot_len_o,
  output iter_t             w_d0_len_o,
  output addr_t             w_d0_stride_o,
  output iter_t             w_d1_len_o,
  output addr_t             w_d1_stride_o,
  output logic              w_req_start_o,
  output addr_t             z_base_addr_o,
  output addr_t             z_tot_len_o,
  output iter_t             z_d0_len_o,
  output addr_t             z_d0_stride_o,
  output iter_t             z_d1_len_o,
  output addr_t             z_d1_stride_o,
  output logic              z_req_start_o
);

  logic x_refetch;

  // X reads one row per beat, ArrayWidth rows per tile
  assign x_base_addr_o = cfg_x_addr_i + x_offs_i;
  assign x_tot_len_o   = addr_t'(x_reads_i);
  assign x_d0_len_o    = iter_t'(1);
  assign x_d0_stride_o = '0;
  assign x_d1_len_o    = iter_t'(ArrayWidth);
  assign x_d1_stride_o = cfg_x_d1_stride_i;

  // In dequant mode the W port fetches scales, which share one row per group
  assign w_base_addr_o = cfg_dequant_en_i ? cfg_scales_addr_i : cfg_w_addr_i;
  assign w_tot_len_o   = cfg_w_tot_len_i;
  assign w_d0_len_o    = cfg_w_rows_i;
  assign w_d0_stride_o = cfg_dequant_en_i ? '0 : cfg_w_d0_stride_i;
  assign w_d1_len_o    = cfg_w_iters_i;
  assign w_d1_stride_o = addr_t'(TileJump);

  assign z_base_addr_o = cfg_z_addr_i;
  assign z_tot_len_o   = cfg_z_tot_len_i;
  assign z_d0_len_o    = iter_t'(ArrayWidth);
  assign z_d0_stride_o = cfg_z_d0_stride_i;
  assign z_d1_len_o    = cfg_w_iters_i;
  assign z_d1_stride_o = addr_t'(TileJump);

  // X is restarted for every further tile until the job total is reached
  assign x_refetch = (x_read_cnt_i != '0) && (x_read_cnt_i < cfg_tot_x_read_i);

  assign x_req_start_o = x_ready_start_i && (first_load_i || x_refetch);
  assign w_req_start_o = first_load_i && w_ready_start_i;
  assign z_req_start_o = first_load_i && z_ready_start_i;

  // X never reports more tiles than the job total
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_read_cnt_i <= cfg_tot_x_read_i);

endmodule : stream_config

`default_nettype wire

/* source/group_bias_gen.sv */
/*
 * Turns each incoming group index into a scales offset and a zeros offset.
 * Both outputs are joined so they transfer in the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module group_bias_gen
  import memsched_pkg::*;
#(
  parameter int unsigned GroupIdWidth = 8
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire addr_t                cfg_w_d0_stride_i,
  input  wire qint_fmt_e            cfg_qint_fmt_i,
  input  wire logic                 gidx_valid_i,
  input  wire [GroupIdWidth:0]      gidx_data_i,
  output logic                      gidx_ready_o,
  output logic                      scales_valid_o,
  output addr_t                     scales_bias_o,
  output logic                      scales_skip_o,
  input  wire logic                 scales_ready_i,
  output logic                      zeros_valid_o,
  output addr_t                     zeros_bias_o,
  output logic                      zeros_skip_o,
  input  wire logic                 zeros_ready_i
);

  logic [GroupIdWidth-1:0] gidx;
  logic                    gidx_skip;
  logic [15:0]             scales_stride;
  logic [15:0]             zeros_stride;

  assign gidx      = gidx_data_i[GroupIdWidth-1:0];
  assign gidx_skip = gidx_data_i[GroupIdWidth];

  // Zeros are packed like the weights, so their row pitch shrinks
  assign scales_stride = cfg_w_d0_stride_i[15:0];
  assign zeros_stride  = scales_stride >> qint_shift(cfg_qint_fmt_i);

  assign scales_bias_o = addr_t'(gidx) * addr_t'(scales_stride);
  assign zeros_bias_o  = addr_t'(gidx) * addr_t'(zeros_stride);
  assign scales_skip_o = gidx_skip;
  assign zeros_skip_o  = gidx_skip;

  // Join: consume an index only when both consumers can take it
  assign gidx_ready_o   = scales_ready_i && zeros_ready_i;
  assign scales_valid_o = gidx_valid_i && gidx_ready_o;
  assign zeros_valid_o  = gidx_valid_i && gidx_ready_o;

  // A stalled index is held upstream until the join accepts it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    gidx_valid_i && !gidx_ready_o |=> $stable(gidx_data_i));

endmodule : group_bias_gen

`default_nettype wire

/* source/memory_scheduler.sv */
/*
 * Memory scheduler of the matrix-multiply accelerator. Joins the X tile
 * walker, the stream configuration and the group bias generator.
 */

`timescale 1ns/1ps
`default_nettype none

module memory_scheduler
  import memsched_pkg::*;
#(
  parameter int unsigned ArrayWidth   = 8,
  parameter int unsigned GroupIdWidth = 8
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            clear_i,
  input  wire addr_t           cfg_x_addr_i,
  input  wire addr_t           cfg_w_addr_i,
  input  wire addr_t           cfg_scales_addr_i,
  input  wire addr_t           cfg_z_addr_i,
  input  wire iter_t           cfg_x_col_iters_i,
  input  wire iter_t           cfg_x_row_iters_i,
  input  wire iter_t           cfg_w_iters_i,
  input  wire iter_t           cfg_w_rows_i,
  input  wire addr_t           cfg_x_rows_offs_i,
  input  wire addr_t           cfg_x_d1_stride_i,
  input  wire addr_t           cfg_w_d0_stride_i,
  input  wire addr_t           cfg_z_d0_stride_i,
  input  wire addr_t           cfg_w_tot_len_i,
  input  wire addr_t           cfg_z_tot_len_i,
  input  wire iter_t           cfg_tot_x_read_i,
  input  wire iter_t           cfg_x_leftover_i,
  input  wire logic            cfg_dequant_en_i,
  input  wire qint_fmt_e       cfg_qint_fmt_i,
  input  wire logic            first_load_i,
  input  wire logic            x_done_i,
  input  wire logic            x_ready_start_i,
  input  wire logic            w_ready_start_i,
  input  wire logic            z_ready_start_i,
  output addr_t                x_base_addr_o,
  output addr_t                x_tot_len_o,
  output iter_t                x_d0_len_o,
  output addr_t                x_d0_stride_o,
  output iter_t                x_d1_len_o,
  output addr_t                x_d1_stride_o,
  output logic                 x_req_start_o,
  output addr_t                w_base_addr_o,
  output addr_t                w_tot_len_o,
  output iter_t                w_d0_len_o,
  output addr_t                w_d0_stride_o,
  output iter_t                w_d1_len_o,
  output addr_t                w_d1_stride_o,
  output logic                 w_req_start_o,
  output addr_t                z_base_addr_o,
  output addr_t                z_tot_len_o,
  output iter_t                z_d0_len_o,
  output addr_t                z_d0_stride_o,
  output iter_t                z_d1_len_o,
  output addr_t                z_d1_stride_o,
  output logic                 z_req_start_o,
  input  wire logic            gidx_valid_i,
  input  wire [GroupIdWidth:0] gidx_data_i,
  output logic                 gidx_ready_o,
  output logic                 scales_valid_o,
  output addr_t                scales_bias_o,
  output logic                 scales_skip_o,
  input  wire logic            scales_ready_i,
  output logic                 zeros_valid_o,
  output addr_t                zeros_bias_o,
  output logic                 zeros_skip_o,
  input  wire logic            zeros_ready_i
);

  addr_t                        x_offs;
  logic [$clog2(ArrayWidth):0]  x_reads;
  iter_t                        x_read_cnt;

  x_tile_walker #(
    .ArrayWidth   (ArrayWidth)
  ) i_x_tile_walker (
    .x_offs_o     (x_offs),
    .x_reads_o    (x_reads),
    .x_read_cnt_o (x_read_cnt),
    .*
  );

  stream_config #(
    .ArrayWidth   (ArrayWidth)
  ) i_stream_config (
    .x_offs_i     (x_offs),
    .x_reads_i    (x_reads),
    .x_read_cnt_i (x_read_cnt),
    .*
  );

  group_bias_gen #(
    .GroupIdWidth (GroupIdWidth)
  ) i_group_bias_gen (
    .*
  );

endmodule : memory_scheduler

`default_nettype wire

/* verification/memsched_checker.sv */
/*
 * Checker of the memory scheduler testbench. Keeps its own model of the X
 * tile walk and compares the DUT ports with it on every rising clock edge.
 */

`timescale 1ns/1ps
`default_nettype none

module memsched_checker
  import memsched_pkg::*;
#(
  parameter int unsigned ArrayWidth   = 8,
  parameter int unsigned GroupIdWidth = 8
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              clear_i,
  input  wire addr_t             cfg_x_addr_i,
  input  wire addr_t             cfg_w_addr_i,
  input  wire addr_t             cfg_scales_addr_i,
  input  wire addr_t             cfg_z_addr_i,
  input  wire iter_t             cfg_x_col_iters_i,
  input  wire iter_t             cfg_x_row_iters_i,
  input  wire iter_t             cfg_w_iters_i,
  input  wire iter_t             cfg_w_rows_i,
  input  wire addr_t             cfg_x_rows_offs_i,
  input  wire addr_t             cfg_x_d1_stride_i,
  input  wire addr_t             cfg_w_d0_stride_i,
  input  wire addr_t             cfg_z_d0_stride_i,
  input  wire addr_t             cfg_w_tot_len_i,
  input  wire addr_t             cfg_z_tot_len_i,
  input  wire iter_t             cfg_tot_x_read_i,
  input  wire iter_t             cfg_x_leftover_i,
  input  wire logic              cfg_dequant_en_i,
  input  wire qint_fmt_e         cfg_qint_fmt_i,
  input  wire logic              first_load_i,
  input  wire logic              x_done_i,
  input  wire logic              x_ready_start_i,
  input  wire logic              w_ready_start_i,
  input  wire logic              z_ready_start_i,
  input  wire addr_t             x_base_addr_o,
  input  wire addr_t             x_tot_len_o,
  input  wire iter_t             x_d0_len_o,
  input  wire addr_t             x_d0_stride_o,
  input  wire iter_t             x_d1_len_o,
  input  wire addr_t             x_d1_stride_o,
  input  wire logic              x_req_start_o,
  input  wire addr_t             w_base_addr_o,
  input  wire addr_t             w_tot_len_o,
  input  wire iter_t             w_d0_len_o,
  input  wire addr_t             w_d0_stride_o,
  input  wire iter_t             w_d1_len_o,
  input  wire addr_t             w_d1_stride_o,
  input  wire logic              w_req_start_o,
  input  wire addr_t             z_base_addr_o,
  input  wire addr_t             z_tot_len_o,
  input  wire iter_t             z_d0_len_o,
  input  wire addr_t             z_d0_stride_o,
  input  wire iter_t             z_d1_len_o,
  input  wire addr_t             z_d1_stride_o,
  input  wire logic              z_req_start_o,
  input  wire logic              gidx_valid_i,
  input  wire [GroupIdWidth:0]   gidx_data_i,
  input  wire logic              gidx_ready_o,
  input  wire logic              scales_valid_o,
  input  wire addr_t             scales_bias_o,
  input  wire logic              scales_skip_o,
  input  wire logic              scales_ready_i,
  input  wire logic              zeros_valid_o,
  input  wire addr_t             zeros_bias_o,
  input  wire logic              zeros_skip_o,
  input  wire logic              zeros_ready_i,
  output int                     err_cnt_o
);

  int unsigned col;
  int unsigned wgt;
  int unsigned row;
  int unsigned rcnt;
  addr_t       col_offs;
  addr_t       row_offs;

  // Zeros offset uses the stride narrowed by 0, 1 or 2 bits for 8, 4 and 2 bit formats
  function automatic addr_t expected_zeros_bias(addr_t idx, addr_t stride, qint_fmt_e fmt);
    addr_t narrow;
    narrow = {16'h0, stride[15:0]};
    if (fmt == QINT_4) narrow = narrow >> 1;
    else if (fmt == QINT_2) narrow = narrow >> 2;
    return idx * narrow;
  endfunction

  task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      err_cnt_o++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic restart_walk();
    col      = 0;
    wgt      = 0;
    row      = 0;
    rcnt     = 0;
    col_offs = '0;
    row_offs = '0;
  endtask

  initial err_cnt_o = 0;

  always @(posedge clk_i) begin : compare_and_model
    addr_t idx;
    logic  join_ok;
    logic  x_window;
    if (!rst_ni) begin
      restart_walk();
    end else begin
      idx      = addr_t'(gidx_data_i[GroupIdWidth-1:0]);
      join_ok  = scales_ready_i && zeros_ready_i;
      x_window = (rcnt >= 1) && (rcnt < 32'(cfg_tot_x_read_i));
      compare("x_base_addr_o", x_base_addr_o, cfg_x_addr_i + col_offs + row_offs);
      if (row == cfg_x_row_iters_i - 1 && cfg_x_leftover_i != 0)
        compare("x_tot_len_o", x_tot_len_o, 32'(cfg_x_leftover_i));
      else
        compare("x_tot_len_o", x_tot_len_o, 32'(ArrayWidth));
      compare("x_d0_len_o", 32'(x_d0_len_o), 32'd1);
      compare("x_d0_stride_o", x_d0_stride_o, 32'h0);
      compare("x_d1_len_o", 32'(x_d1_len_o), 32'(ArrayWidth));
      compare("x_d1_stride_o", x_d1_stride_o, cfg_x_d1_stride_i);
      compare("x_req_start_o", 32'(x_req_start_o),
              32'(x_ready_start_i && (first_load_i || x_window)));
      compare("w_req_start_o", 32'(w_req_start_o), 32'(first_load_i && w_ready_start_i));
      compare("z_req_start_o", 32'(z_req_start_o), 32'(first_load_i && z_ready_start_i));
      compare("w_base_addr_o", w_base_addr_o,
              cfg_dequant_en_i ? cfg_scales_addr_i : cfg_w_addr_i);
      compare("w_tot_len_o", w_tot_len_o, cfg_w_tot_len_i);
      compare("w_d0_len_o", 32'(w_d0_len_o), 32'(cfg_w_rows_i));
      compare("w_d0_stride_o", w_d0_stride_o, cfg_dequant_en_i ? 32'h0 : cfg_w_d0_stride_i);
      compare("w_d1_len_o", 32'(w_d1_len_o), 32'(cfg_w_iters_i));
      compare("w_d1_stride_o", w_d1_stride_o, 32'(TileJump));
      compare("z_base_addr_o", z_base_addr_o, cfg_z_addr_i);
      compare("z_tot_len_o", z_tot_len_o, cfg_z_tot_len_i);
      compare("z_d0_len_o", 32'(z_d0_len_o), 32'(ArrayWidth));
      compare("z_d0_stride_o", z_d0_stride_o, cfg_z_d0_stride_i);
      compare("z_d1_len_o", 32'(z_d1_len_o), 32'(cfg_w_iters_i));
      compare("z_d1_stride_o", z_d1_stride_o, 32'(TileJump));
      compare("gidx_ready_o", 32'(gidx_ready_o), 32'(join_ok));
      compare("scales_valid_o", 32'(scales_valid_o), 32'(gidx_valid_i && join_ok));
      compare("zeros_valid_o", 32'(zeros_valid_o), 32'(gidx_valid_i && join_ok));
      compare("scales_bias_o", scales_bias_o, idx * {16'h0, cfg_w_d0_stride_i[15:0]});
      compare("zeros_bias_o", zeros_bias_o,
              expected_zeros_bias(idx, cfg_w_d0_stride_i, cfg_qint_fmt_i));
      compare("scales_skip_o", 32'(scales_skip_o), 32'(gidx_data_i[GroupIdWidth]));
      compare("zeros_skip_o", 32'(zeros_skip_o), 32'(gidx_data_i[GroupIdWidth]));
      // Step the model walk over columns, then weights, then rows
      if (clear_i) begin
        restart_walk();
      end else if (x_done_i) begin
        rcnt++;
        if (col == cfg_x_col_iters_i - 1) begin
          col = 0;
          col_offs = '0;
          if (wgt == cfg_w_iters_i - 1) begin
            wgt = 0;
            if (row == cfg_x_row_iters_i - 1) begin
              row = 0;
              row_offs = '0;
            end else begin
              row++;
              row_offs = row_offs + cfg_x_rows_offs_i;
            end
          end else begin
            wgt++;
          end
        end else begin
          col++;
          col_offs = col_offs + addr_t'(TileJump);
        end
      end
    end
  end

endmodule : memsched_checker

`default_nettype wire

/* verification/tb_memory_scheduler.sv */
/*
 * Testbench of the memory scheduler. Runs two full X walks, then random
 * group indexes under random back-pressure; the checker does the comparing.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_memory_scheduler;
  import memsched_pkg::*;

  localparam int unsigned ArrayWidth   = 8;
  localparam int unsigned GroupIdWidth = 8;
  localparam int DonePulses    = 18;
  localparam int GidxCycles    = 300;
  localparam int StimCycles    = 5 + 3 + 2 * (2 + 2 * DonePulses) + GidxCycles + 4;
  localparam int TimeoutCycles = StimCycles + 100;

  logic clk_i, rst_ni, clear_i;
  addr_t cfg_x_addr_i, cfg_w_addr_i, cfg_scales_addr_i, cfg_z_addr_i;
  iter_t cfg_x_col_iters_i, cfg_x_row_iters_i, cfg_w_iters_i, cfg_w_rows_i;
  addr_t cfg_x_rows_offs_i, cfg_x_d1_stride_i, cfg_w_d0_stride_i, cfg_z_d0_stride_i;
  addr_t cfg_w_tot_len_i, cfg_z_tot_len_i;
  iter_t cfg_tot_x_read_i, cfg_x_leftover_i;
  logic cfg_dequant_en_i;
  qint_fmt_e cfg_qint_fmt_i;
  logic first_load_i, x_done_i, x_ready_start_i, w_ready_start_i, z_ready_start_i;
  addr_t x_base_addr_o, x_tot_len_o, x_d0_stride_o, x_d1_stride_o;
  addr_t w_base_addr_o, w_tot_len_o, w_d0_stride_o, w_d1_stride_o;
  addr_t z_base_addr_o, z_tot_len_o, z_d0_stride_o, z_d1_stride_o;
  iter_t x_d0_len_o, x_d1_len_o, w_d0_len_o, w_d1_len_o, z_d0_len_o, z_d1_len_o;
  logic x_req_start_o, w_req_start_o, z_req_start_o;
  logic gidx_valid_i, gidx_ready_o, scales_ready_i, zeros_ready_i;
  logic [GroupIdWidth:0] gidx_data_i;
  logic scales_valid_o, scales_skip_o, zeros_valid_o, zeros_skip_o;
  addr_t scales_bias_o, zeros_bias_o;
  int err_cnt_o;
  int seed = 32'h6cb5_195c;
  int cycles = 0;

  memory_scheduler #(
    .ArrayWidth   (ArrayWidth),
    .GroupIdWidth (GroupIdWidth)
  ) i_memory_scheduler (
    .*
  );

  memsched_checker #(
    .ArrayWidth   (ArrayWidth),
    .GroupIdWidth (GroupIdWidth)
  ) i_checker (
    .*
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic walk_x(input bit dequant, input iter_t leftover);
    @(negedge clk_i);
    cfg_dequant_en_i = dequant;
    cfg_x_leftover_i = leftover;
    // Ready without first load probes both ends of the refetch window
    x_ready_start_i = 1'b1;
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    for (int i = 0; i < DonePulses; i++) begin
      x_done_i = 1'b1;
      x_ready_start_i = 1'($random(seed));
      w_ready_start_i = 1'($random(seed));
      z_ready_start_i = 1'($random(seed));
      @(negedge clk_i);
      x_done_i = 1'b0;
      x_ready_start_i = 1'($random(seed));
      @(negedge clk_i);
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    clear_i = 1'b0;
    cfg_x_addr_i = 32'h1000;
    cfg_w_addr_i = 32'h2000;
    cfg_scales_addr_i = 32'h3000;
    cfg_z_addr_i = 32'h4000;
    cfg_x_col_iters_i = 16'd3;
    cfg_w_iters_i = 16'd2;
    cfg_x_row_iters_i = 16'd3;
    cfg_w_rows_i = 16'd8;
    cfg_x_rows_offs_i = 32'h100;
    cfg_x_d1_stride_i = 32'h40;
    cfg_w_d0_stride_i = 32'h0001_00a4;
    cfg_z_d0_stride_i = 32'h20;
    cfg_w_tot_len_i = 32'd48;
    cfg_z_tot_len_i = 32'd64;
    cfg_tot_x_read_i = iter_t'(DonePulses);
    cfg_x_leftover_i = 16'd5;
    cfg_dequant_en_i = 1'b0;
    cfg_qint_fmt_i = QINT_8;
    first_load_i = 1'b0;
    x_done_i = 1'b0;
    x_ready_start_i = 1'b0;
    w_ready_start_i = 1'b0;
    z_ready_start_i = 1'b0;
    gidx_valid_i = 1'b0;
    gidx_data_i = '0;
    scales_ready_i = 1'b0;
    zeros_ready_i = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    // First load with every stream ready, then with W not ready
    first_load_i = 1'b1;
    x_ready_start_i = 1'b1;
    w_ready_start_i = 1'b1;
    z_ready_start_i = 1'b1;
    @(negedge clk_i);
    w_ready_start_i = 1'b0;
    @(negedge clk_i);
    first_load_i = 1'b0;
    walk_x(1'b0, 16'd5);
    walk_x(1'b1, 16'd0);
    for (int i = 0; i < GidxCycles; i++) begin
      // Hold a stalled index, otherwise present a fresh one
      if (!(gidx_valid_i && !(scales_ready_i && zeros_ready_i))) begin
        gidx_valid_i = 1'($random(seed));
        gidx_data_i = (GroupIdWidth + 1)'($random(seed));
      end
      scales_ready_i = 1'($random(seed));
      zeros_ready_i = 1'($random(seed));
      cfg_qint_fmt_i = qint_fmt_e'(i % 3);
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    $display("Checks done with %0d errors", err_cnt_o);
    if (err_cnt_o == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_memory_scheduler

`default_nettype wire

/* memory_scheduler.f */
source/memsched_pkg.sv
source/x_tile_walker.sv
source/stream_config.sv
source/group_bias_gen.sv
source/memory_scheduler.sv
verification/memsched_checker.sv
verification/tb_memory_scheduler.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f memory_scheduler.f \
  --top-module tb_memory_scheduler -o tb_sim > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  echo "Build or simulation ended with an error"
grep -q "^Verification passed$" sim.log 2>/dev/null && echo "PASS" && exit 0 ||
  { echo "FAIL"; exit 1; }
